//--- uart.f
+incdir+.
uart_pkg.sv
uart_ifs.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_top.sv
uart_assertions.sv
uart_scoreboard.sv
tb_uart.sv

//--- tb_uart.sv
// Testbench top for the UART. A timed-out wait counts as an error and the run
// goes on; rxd idles one bit period after each driven frame.
`include "uart_macros.svh"

module tb_uart;

  localparam int BIT_LEN = `UART_DIV_RATE + 1;
  localparam int LIMIT   = 40 * BIT_LEN;  // cycles allowed per wait

  logic        clk;
  logic        reset;
  logic        req;
  logic        we;
  logic        addr;
  logic [7:0]  wdata;
  logic        ack;
  logic [7:0]  rdata;
  logic        rxd;
  logic        txd;
  logic [31:0] rng;
  logic [7:0]  last_read;
  int          tb_errors;
  int          tests_failed;
  int          err_mark;
  int          frames;
  int          errs;

  uart_top u_dut (.*);
  uart_scoreboard u_sb (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int total_errors();
    return tb_errors + u_sb.errors + u_dut.u_regs.u_assert.fails;
  endfunction

  task automatic timed_out(input string what);
    tb_errors++;
    $display("timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      tb_errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // one four-phase host access, rdata kept in last_read
  task automatic host_access(input logic w, input logic a, input logic [7:0] d);
    int n;
    @(posedge clk);
    req   <= 1'b1;
    we    <= w;
    addr  <= a;
    wdata <= d;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (ack !== 1'b1 && n < LIMIT);
    if (ack !== 1'b1)
      timed_out("ack to rise");
    last_read = rdata;
    req <= 1'b0;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (ack !== 1'b0 && n < LIMIT);
    if (ack !== 1'b0)
      timed_out("ack to fall");
  endtask

  task automatic send_frame(input logic [7:0] d, input logic stop_level);
    logic [9:0] frame;
    frame = {stop_level, d, `UART_START_BIT};
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rxd <= (i < 10) ? frame[i] : `UART_STOP_BIT;  // last slot is idle
      repeat (`UART_DIV_RATE) @(posedge clk);
    end
  endtask

  task automatic wait_status(input logic [7:0] mask, input string what);
    logic [7:0] st;
    int n;
    n  = 0;
    st = u_dut.u_regs.status_now;
    while ((st & mask) != mask && n < LIMIT)
    begin
      @(posedge clk);
      n++;
      st = u_dut.u_regs.status_now;
    end
    if ((st & mask) != mask)
      timed_out(what);
  endtask

  // scoreboard state is read between clock edges
  task automatic wait_tx_idle();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while ((u_sb.tx_pending != 0 || u_sb.tx_active) && n < LIMIT);
    if (u_sb.tx_pending != 0 || u_sb.tx_active)
      timed_out("txd frames to finish");
  endtask

  task automatic end_test(input string name);
    @(negedge clk);  // after all posedge updates
    if (total_errors() != err_mark)
    begin
      tests_failed++;
      $display("test %s: failed", name);
    end
    else
      $display("test %s: ok", name);
    err_mark = total_errors();
  endtask

  initial
  begin
    reset        = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = 1'b0;
    wdata        = '0;
    rxd          = `UART_STOP_BIT;
    rng          = 32'hb22d;
    tb_errors    = 0;
    tests_failed = 0;
    err_mark     = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b1;

    @(posedge clk);
    check_bit("txd", 1'b1, txd);
    check_bit("ack", 1'b0, ack);
    host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    end_test("reset state");

    repeat (4)
    begin
      rng = xorshift(rng);
      host_access(1'b1, `UART_ADDR_DATA, rng[7:0]);
      wait_tx_idle();
    end
    end_test("single transmit");

    frames = u_sb.tx_frames;
    rng = xorshift(rng);
    host_access(1'b1, `UART_ADDR_DATA, rng[7:0]);
    host_access(1'b1, `UART_ADDR_DATA, rng[15:8]);  // held until first frame ends
    if (u_sb.tx_frames != frames + 1)
    begin
      tb_errors++;
      $display("second write acked at %0t before the first frame ended", $time);
    end
    host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    check_bit("rdata[4] tx_busy", 1'b1, last_read[4]);
    wait_tx_idle();
    end_test("back-pressure");

    repeat (3)
    begin
      rng = xorshift(rng);
      send_frame(rng[7:0], `UART_STOP_BIT);
      wait_status(8'h80, "rx_valid");
      host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
      host_access(1'b0, `UART_ADDR_DATA, 8'h00);
      host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    end
    end_test("receive");

    rng = xorshift(rng);
    send_frame(rng[7:0], `UART_START_BIT);  // stop bit driven low
    wait_status(8'h40, "frame_err");
    host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    send_frame(rng[15:8], `UART_STOP_BIT);
    wait_status(8'h80, "rx_valid");
    send_frame(rng[23:16], `UART_STOP_BIT);
    wait_status(8'h20, "overrun");
    host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    host_access(1'b0, `UART_ADDR_DATA, 8'h00);
    host_access(1'b0, `UART_ADDR_STATUS, 8'h00);
    end_test("errors");

    errs = total_errors();
    $display("5 tests, %0d failed, %0d scoreboard checks, %0d errors",
             tests_failed, u_sb.checks, errs);
    if (errs == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- uart_scoreboard.sv
// Checks txd frames against acked data writes and predicts host reads from
// a model fed by rxd. Expects rxd to idle one bit period between frames.
`include "uart_macros.svh"

module uart_scoreboard (
  input logic       clk,
  input logic       reset,
  input logic       req,
  input logic       we,
  input logic       addr,
  input logic [7:0] wdata,
  input logic       ack,
  input logic [7:0] rdata,
  input logic       rxd,
  input logic       txd
);

  localparam int BIT_LEN   = `UART_DIV_RATE + 1;
  localparam int FRAME_LEN = 10 * BIT_LEN;
  localparam int MID       = BIT_LEN / 2;

  logic [7:0] tx_expected [$];  // acked data writes in order
  int         tx_pending;
  int         checks;
  int         errors;
  int         tx_frames;
  logic       tx_active;
  logic       tx_busy_prev;  // line busy in the cycle rdata was latched
  logic       tx_level;
  int         tx_pos;
  logic [9:0] tx_bits;
  logic       rx_active;
  int         rx_pos;
  logic [7:0] rx_shift;
  logic       ack_prev;
  logic       m_rx_valid;
  logic       m_frame_err;
  logic       m_overrun;
  logic [7:0] m_held;

  // status view is rx_valid, frame_err, overrun, tx_busy, then zeros
  function automatic logic [7:0] expected_rdata(input logic a, input logic busy);
    if (a == `UART_ADDR_DATA)
      return m_held;
    return {m_rx_valid, m_frame_err, m_overrun, busy, 4'b0000};
  endfunction

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %02h got %02h", $time, name, exp, act);
    end
  endtask

  task automatic close_tx_frame();
    checks++;
    if (tx_bits[0] !== `UART_START_BIT || tx_bits[9] !== `UART_STOP_BIT)
    begin
      errors++;
      $display("txd frame ending at %0t has a bad start or stop bit", $time);
    end
    if (tx_expected.size() == 0)
    begin
      errors++;
      $display("txd sent a frame at %0t with no byte written", $time);
    end
    else
      check_value("txd byte", tx_expected.pop_front(), tx_bits[8:1]);
  endtask

  task automatic take_rx_bit(input int k);
    if (k == 0 && rxd != `UART_START_BIT)
      rx_active = 1'b0;  // glitch, no frame
    else if (k >= 1 && k <= 8)
      rx_shift[k-1] = rxd;
    else if (k == 9)
    begin
      rx_active = 1'b0;
      if (rxd == `UART_STOP_BIT)
      begin
        m_overrun  = m_overrun | m_rx_valid;
        m_rx_valid = 1'b1;
        m_held     = rx_shift;
      end
      else
        m_frame_err = 1'b1;
    end
  endtask

  always @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      tx_expected.delete();
      tx_pending   = 0;
      checks       = 0;
      errors       = 0;
      tx_frames    = 0;
      tx_active    = 1'b0;
      tx_busy_prev = 1'b0;
      rx_active    = 1'b0;
      ack_prev     = 1'b0;
      m_rx_valid   = 1'b0;
      m_frame_err  = 1'b0;
      m_overrun    = 1'b0;
      m_held       = '0;
    end
    else
    begin
      if (ack && !ack_prev && !we)
      begin
        check_value(addr ? "rdata (data)" : "rdata (status)",
                    expected_rdata(addr, tx_busy_prev), rdata);
        if (addr == `UART_ADDR_DATA)
          m_rx_valid = 1'b0;
        else
        begin
          m_frame_err = 1'b0;
          m_overrun   = 1'b0;
        end
      end
      else if (ack && !ack_prev && addr == `UART_ADDR_DATA)
        tx_expected.push_back(wdata);
      ack_prev = ack;

      if (!tx_active && txd == `UART_START_BIT)
      begin
        tx_active = 1'b1;
        tx_pos    = 0;
      end
      else if (tx_active)
        tx_pos++;
      tx_busy_prev = tx_active;
      if (tx_active)
      begin
        if (tx_pos % BIT_LEN == 0)
          tx_level = txd;
        else if (txd !== tx_level)
        begin
          errors++;
          $display("txd changed inside bit %0d at %0t", tx_pos / BIT_LEN, $time);
        end
        if (tx_pos % BIT_LEN == MID)
          tx_bits[tx_pos / BIT_LEN] = txd;  // mid-bit sample
        if (tx_pos == FRAME_LEN - 1)
        begin
          tx_active = 1'b0;
          tx_frames++;
          close_tx_frame();
        end
      end
      tx_pending = tx_expected.size();

      if (!rx_active && rxd == `UART_START_BIT)
      begin
        rx_active = 1'b1;
        rx_pos    = 0;
      end
      else if (rx_active)
        rx_pos++;
      if (rx_active && rx_pos % BIT_LEN == MID)
        take_rx_bit(rx_pos / BIT_LEN);
    end
  end

endmodule

//--- uart_assertions.sv
// Bound into uart_regs. Checks the host handshake and the tx launch rule;
// fails counts every assertion failure for the testbench summary.

module uart_assertions (
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack,
  input logic tx_start,
  input logic tx_busy
);

  int fails = 0;

  // ack only answers a request that is still up
  ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
    $rose(ack) |-> req && $past(req))
  else
  begin
    $error("ack rose without req");
    fails++;
  end

  ack_follows_req: assert property (@(posedge clk) disable iff (!reset)
    $fell(req) |=> $fell(ack))
  else
  begin
    $error("ack did not fall one cycle after req fell");
    fails++;
  end

  start_when_idle: assert property (@(posedge clk) disable iff (!reset)
    tx_start |-> !tx_busy)
  else
  begin
    $error("tx start pulsed while the transmitter was busy");
    fails++;
  end

endmodule

bind uart_regs uart_assertions u_assert (
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .tx_start (tx_port.start),
  .tx_busy  (tx_port.busy)
);

//--- uart_top.sv
// UART peripheral top, 8N1 at a fixed divider. One received byte is held;
// a later byte overwrites it and flags overrun.

module uart_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       req,
  input  logic       we,
  input  logic       addr,
  input  logic [7:0] wdata,
  output logic       ack,
  output logic [7:0] rdata,
  input  logic       rxd,
  output logic       txd
);

  uart_tx_if tx_bus ();
  uart_rx_if rx_bus ();

  uart_regs u_regs (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .we      (we),
    .addr    (addr),
    .wdata   (wdata),
    .ack     (ack),
    .rdata   (rdata),  // union flattens to the plain byte
    .tx_port (tx_bus.regs),
    .rx_port (rx_bus.regs)
  );

  uart_tx u_tx (
    .clk     (clk),
    .reset   (reset),
    .tx_port (tx_bus.tx),
    .txd     (txd)
  );

  uart_rx u_rx (
    .clk     (clk),
    .reset   (reset),
    .rxd     (rxd),
    .rx_port (rx_bus.rx)
  );

endmodule

//--- uart_regs.sv
// Host register block on a four-phase req/ack bus. A data write while the
// transmitter is busy holds ack low until that frame ends.
`include "uart_macros.svh"

module uart_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  logic                  we,
  input  logic                  addr,
  input  logic [7:0]            wdata,
  output logic                  ack,
  output uart_pkg::uart_rdata_u rdata,
  uart_tx_if.regs               tx_port,
  uart_rx_if.regs               rx_port
);
  import uart_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_HOLD = 2'd1;  // data write waiting for tx
  localparam logic [1:0] ST_ACK  = 2'd2;  // ack high until req drops

  logic [1:0]              state;
  logic                    rx_valid;
  logic                    frame_err;
  logic                    overrun;
  logic [`UART_DATA_W-1:0] hold_byte;
  uart_status_t            status_now;
  logic                    tx_free;
  logic                    access;
  logic                    data_wr;
  logic                    data_rd;
  logic                    stat_rd;
  logic                    launch;

  assign access  = state == ST_IDLE && req;
  assign data_wr = access && we && addr == `UART_ADDR_DATA;
  assign data_rd = access && !we && addr == `UART_ADDR_DATA;
  assign stat_rd = access && !we && addr == `UART_ADDR_STATUS;
  assign tx_free = !tx_port.busy && !tx_port.start;  // start pending counts as busy
  assign launch  = (data_wr && tx_free) || (state == ST_HOLD && tx_port.frame_end);

  always_comb
  begin
    status_now           = '0;
    status_now.rx_valid  = rx_valid;
    status_now.frame_err = frame_err;
    status_now.overrun   = overrun;
    status_now.tx_busy   = tx_port.busy;  // live, not sticky
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state         <= ST_IDLE;
      ack           <= 1'b0;
      rdata         <= '0;
      tx_port.start <= 1'b0;
    end
    else
    begin
      tx_port.start <= launch;
      case (state)
        ST_IDLE:
          if (req)
          begin
            if (data_wr && !tx_free)
              state <= ST_HOLD;
            else
            begin
              ack   <= 1'b1;  // status writes land here and do nothing
              state <= ST_ACK;
            end
            if (stat_rd)
              rdata.status <= status_now;
            else if (data_rd)
              rdata.rx_byte <= hold_byte;
          end
        ST_HOLD:
          if (tx_port.frame_end)
          begin
            ack   <= 1'b1;
            state <= ST_ACK;
          end
        ST_ACK:
          if (!req)
          begin
            ack   <= 1'b0;
            state <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // new events win over a clearing read in the same cycle
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
      overrun   <= 1'b0;
    end
    else
    begin
      if (rx_port.frame_end)
        rx_valid <= 1'b1;
      else if (data_rd)
        rx_valid <= 1'b0;
      if (rx_port.frame_end && rx_valid && !data_rd)
        overrun <= 1'b1;  // older byte is overwritten
      else if (stat_rd)
        overrun <= 1'b0;
      if (rx_port.frame_err)
        frame_err <= 1'b1;
      else if (stat_rd)
        frame_err <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_port.frame_end)
      hold_byte <= rx_port.data;
    if (data_wr)
      tx_port.data <= wdata;  // stays put while held in ST_HOLD
  end

endmodule

//--- uart_tx.sv
// 8N1 transmitter. start is ignored while a frame is running; txd falls
// one cycle after start and busy covers exactly ten bit periods.
`include "uart_macros.svh"

module uart_tx (
  input  logic   clk,
  input  logic   reset,
  uart_tx_if.tx  tx_port,
  output logic   txd
);

  logic [`UART_DIV_CNT_W-1:0] div_cnt;
  logic [`UART_BIT_CNT_W-1:0] bit_cnt;
  logic [`UART_DATA_W+1:0]    frame_sr;  // stop, data, start

  assign txd = frame_sr[0];  // bit 0 is on the line

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      frame_sr          <= '1;  // idle high
      div_cnt           <= `UART_DIV_CNT_W'(`UART_DIV_RATE);
      bit_cnt           <= '0;
      tx_port.busy      <= 1'b0;
      tx_port.frame_end <= 1'b0;
    end
    else
    begin
      tx_port.frame_end <= 1'b0;
      if (!tx_port.busy)
      begin
        if (tx_port.start)
        begin
          frame_sr     <= {`UART_STOP_BIT, tx_port.data, `UART_START_BIT};
          div_cnt      <= `UART_DIV_CNT_W'(`UART_DIV_RATE);
          bit_cnt      <= '0;
          tx_port.busy <= 1'b1;
        end
      end
      else if (div_cnt != '0)
        div_cnt <= div_cnt - 1'b1;
      else
      begin
        div_cnt  <= `UART_DIV_CNT_W'(`UART_DIV_RATE);
        frame_sr <= {`UART_STOP_BIT, frame_sr[`UART_DATA_W+1:1]};  // refill with idle level
        if (bit_cnt == `UART_BIT_CNT_W'(`UART_BIT_CNT_STOP))
        begin
          bit_cnt           <= '0;
          tx_port.busy      <= 1'b0;
          tx_port.frame_end <= 1'b1;  // same edge as busy falling
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

//--- uart_rx.sv
// 8N1 receiver. Samples near mid-bit after a half-period start alignment;
// a start bit that is gone at mid-bit is treated as a glitch and ignored.
`include "uart_macros.svh"

module uart_rx (
  input  logic   clk,
  input  logic   reset,
  input  logic   rxd,
  uart_rx_if.rx  rx_port
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_RECV = 1'b1;

  logic                       state;
  logic [1:0]                 rxd_sync;  // two-flop synchronizer
  logic                       line;
  logic [`UART_DIV_CNT_W-1:0] div_cnt;
  logic [`UART_BIT_CNT_W-1:0] bit_cnt;
  logic                       bit_tick;
  logic                       data_bit;

  assign line     = rxd_sync[1];
  assign bit_tick = state == ST_RECV && div_cnt == '0;
  assign data_bit = bit_cnt != '0 && bit_cnt != `UART_BIT_CNT_W'(`UART_BIT_CNT_STOP);
  assign rx_port.busy = state == ST_RECV;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      rxd_sync          <= {2{`UART_STOP_BIT}};  // line idles high
      state             <= ST_IDLE;
      div_cnt           <= `UART_DIV_CNT_W'(`UART_DIV_RATE / 2);
      bit_cnt           <= '0;
      rx_port.frame_end <= 1'b0;
      rx_port.frame_err <= 1'b0;
    end
    else
    begin
      rxd_sync          <= {rxd_sync[0], rxd};
      rx_port.frame_end <= 1'b0;
      rx_port.frame_err <= 1'b0;
      if (state == ST_IDLE)
      begin
        if (line == `UART_START_BIT)
          state <= ST_RECV;  // half count already loaded
      end
      else if (!bit_tick)
        div_cnt <= div_cnt - 1'b1;
      else if (bit_cnt == '0 && line != `UART_START_BIT)
      begin
        state   <= ST_IDLE;  // glitch, not a start bit
        div_cnt <= `UART_DIV_CNT_W'(`UART_DIV_RATE / 2);
      end
      else if (bit_cnt == `UART_BIT_CNT_W'(`UART_BIT_CNT_STOP))
      begin
        state   <= ST_IDLE;
        bit_cnt <= '0;
        div_cnt <= `UART_DIV_CNT_W'(`UART_DIV_RATE / 2);
        if (line == `UART_STOP_BIT)
          rx_port.frame_end <= 1'b1;
        else
          rx_port.frame_err <= 1'b1;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        div_cnt <= `UART_DIV_CNT_W'(`UART_DIV_RATE);
      end
    end
  end

  // shift register, LSB arrives first
  always_ff @(posedge clk)
  begin
    if (bit_tick && data_bit)
      rx_port.data <= {line, rx_port.data[`UART_DATA_W-1:1]};
  end

endmodule

//--- uart_ifs.sv
// Internal links between the register block and the serial engines.
// Both frame_end strobes and frame_err are single-cycle pulses.
`include "uart_macros.svh"

interface uart_tx_if;
  logic                    start;      // one-cycle launch pulse
  logic [`UART_DATA_W-1:0] data;       // captured by tx on start
  logic                    busy;
  logic                    frame_end;  // pulses as busy falls

  modport regs (
    output start,
    output data,
    input  busy,
    input  frame_end
  );

  modport tx (
    input  start,
    input  data,
    output busy,
    output frame_end
  );
endinterface

interface uart_rx_if;
  logic                    busy;
  logic                    frame_end;  // good stop bit, data valid
  logic [`UART_DATA_W-1:0] data;
  logic                    frame_err;  // stop bit low, data dropped

  modport rx (
    output busy,
    output frame_end,
    output data,
    output frame_err
  );

  modport regs (
    input busy,
    input frame_end,
    input data,
    input frame_err
  );
endinterface

//--- uart_pkg.sv
// Host read word types. The reserved status bits always read as zero.
`include "uart_macros.svh"

package uart_pkg;

  // status register layout, rx_valid in the top bit
  typedef struct packed {
    logic       rx_valid;   // byte waiting in holding register
    logic       frame_err;  // sticky, stop bit sampled low
    logic       overrun;    // sticky, byte lost to a newer one
    logic       tx_busy;    // live transmitter state
    logic [3:0] zero;
  } uart_status_t;

  // read data is decoded by address as status or as the received byte
  typedef union packed {
    uart_status_t                status;
    logic [`UART_DATA_W-1:0]     rx_byte;
  } uart_rdata_u;

endpackage

//--- uart_macros.svh
// Compile-time constants for the 8N1 UART. Baud rate is fixed by UART_DIV_RATE;
// the divider counter width must hold UART_DIV_RATE.
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// clock cycles per bit minus one, 8 cycles per bit in simulation
`define UART_DIV_RATE 7
`define UART_DIV_CNT_W 4

// bit counter covers start, 8 data and stop
`define UART_BIT_CNT_W 4
`define UART_BIT_CNT_STOP 9

// byte width on host and serial side
`define UART_DATA_W 8

// line levels
`define UART_START_BIT 1'b0
`define UART_STOP_BIT 1'b1

// host register map, one address bit
`define UART_ADDR_STATUS 1'b0
`define UART_ADDR_DATA 1'b1

`endif
